// ==== vlog.f ====
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/operand_fetch.sv
hw/branch_unit.sv
hw/id_stage.sv
dv/id_stage_asserts.sv
dv/tb_id_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the id_stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_id_stage \
    -Mdir obj_dir -o sim_id_stage > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_id_stage > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0

// ==== dv/tb_id_stage.sv ====
`timescale 1ns/1ps

module tb_id_stage;

    logic                       clk;
    logic                       resetn;
    logic                       fs_to_ds_valid;
    pipe_pkg::fetch_to_decode_t fs_to_ds_bus;
    logic                       es_allowin;
    pipe_pkg::fwd_src_t         es_fwd;
    pipe_pkg::fwd_src_t         ms_fwd;
    pipe_pkg::wb_write_t        ws_write;
    logic                       ds_allowin;
    logic                       ds_to_es_valid;
    pipe_pkg::decode_to_exe_t   ds_to_es_bus;
    pipe_pkg::branch_redirect_t br_redirect;

    logic [31:0]              reg_val [32]; // expected register contents
    pipe_pkg::decode_to_exe_t last_bus;
    int                       errors = 0;
    int                       tests_run = 0;
    int                       err_start;

    id_stage UUT (.*);

    always #10 clk = ~clk;

    initial begin
        #20us;
        $display("watchdog expired, the run did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic [31:0] enc_3r(input logic [4:0] op5, rk, rj, rd);
        return {6'h00, 4'h0, 2'h1, op5, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i12(input logic [5:0] op6, input logic [3:0] op4,
                                            input logic [11:0] i12, input logic [4:0] rj, rd);
        return {op6, op4, i12, rj, rd};
    endfunction

    function automatic logic [31:0] enc_br(input logic [5:0] op6, input logic [25:0] offs,
                                           input logic [4:0] rj, rd);
        return {op6, offs[15:0], rj, rd};
    endfunction

    function automatic logic [31:0] sext_offs16(input logic [15:0] offs);
        return {{14{offs[15]}}, offs, 2'b00};
    endfunction

    task automatic check_word(input logic [31:0] got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH @%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("%-14s %s (%0d errors)", name, (errors == err_start) ? "ok" : "FAILED",
                 errors - err_start);
    endtask

    // offer one instruction and return 2 ns after the edge that takes it
    task automatic issue(input logic [31:0] inst, input logic [31:0] pc);
        int n;
        n = 0;
        fs_to_ds_valid = 1'b1;
        fs_to_ds_bus   = {inst, pc};
        while (!ds_allowin && n < 40) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (n == 40) begin
            errors++;
            $display("decode stage never accepted instruction at pc %h", pc);
        end
        @(posedge clk);
        #2;
        fs_to_ds_valid = 1'b0;
    endtask

    task automatic preload_regs();
        for (int i = 1; i < 32; i++) begin
            reg_val[i] = $urandom;
            ws_write   = '{1'b1, 5'(i), reg_val[i]};
            @(posedge clk);
            #2;
        end
        ws_write = '0;
    endtask

    task automatic test_alu_reg();
        logic [4:0] ops [8] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h09, 5'h08, 5'h0a, 5'h0b};
        err_start = errors;
        for (int i = 0; i < 8; i++) begin
            issue(enc_3r(ops[i], 5'd3 + 5'(i), 5'd12 + 5'(i), 5'd20 + 5'(i)), 32'h1000);
            check_word(ds_to_es_valid, 1, "valid");
            check_word(ds_to_es_bus.alu_op, 32'd1 << i, "alu_op");
            check_word(ds_to_es_bus.src1, reg_val[12 + i], "src1");
            check_word(ds_to_es_bus.src2, reg_val[3 + i], "src2");
            check_word(ds_to_es_bus.dest, 20 + i, "dest");
            check_word(ds_to_es_bus.rf_we, 1, "rf_we");
        end
        issue(enc_3r(5'h00, 5'd4, 5'd0, 5'd0), 32'h1004);
        check_word(ds_to_es_bus.src1, 0, "r0 read");
        end_test("alu_reg");
    endtask

    task automatic test_immediates();
        logic [11:0] si;
        logic [19:0] i20;
        si  = 12'h800 | 12'($urandom);
        i20 = 20'($urandom);
        err_start = errors;
        issue(enc_i12(6'h00, 4'ha, si, 5'd7, 5'd8), 32'h2000);
        check_word(ds_to_es_bus.src2, {{20{si[11]}}, si}, "addi.w imm");
        check_word(ds_to_es_bus.src1, reg_val[7], "addi.w src1");
        check_word(ds_to_es_bus.alu_op, 32'h001, "addi.w op");
        issue(enc_i12(6'h00, 4'h8, si, 5'd7, 5'd8), 32'h2004);
        check_word(ds_to_es_bus.src2, {{20{si[11]}}, si}, "slti imm");
        check_word(ds_to_es_bus.alu_op, 32'h004, "slti op");
        issue(enc_i12(6'h00, 4'hd, si, 5'd7, 5'd8), 32'h2008);
        check_word(ds_to_es_bus.src2, {20'b0, si}, "andi imm");
        check_word(ds_to_es_bus.alu_op, 32'h010, "andi op");
        issue(enc_i12(6'h00, 4'he, si, 5'd7, 5'd8), 32'h200c);
        check_word(ds_to_es_bus.src2, {20'b0, si}, "ori imm");
        issue(enc_i12(6'h00, 4'hf, si, 5'd7, 5'd8), 32'h2010);
        check_word(ds_to_es_bus.src2, {20'b0, si}, "xori imm");
        check_word(ds_to_es_bus.alu_op, 32'h080, "xori op");
        issue({6'h00, 4'h1, 2'h0, 5'h01, 5'd19, 5'd7, 5'd8}, 32'h2014);
        check_word(ds_to_es_bus.src2, 19, "slli.w ui5");
        check_word(ds_to_es_bus.alu_op, 32'h100, "slli.w op");
        issue({6'h05, 1'b0, i20, 5'd9}, 32'h2018);
        check_word(ds_to_es_bus.src2, {i20, 12'b0}, "lu12i.w imm");
        check_word(ds_to_es_bus.alu_op, 32'h800, "lu12i.w op");
        issue({6'h07, 1'b0, i20, 5'd9}, 32'h201c);
        check_word(ds_to_es_bus.src1, 32'h201c, "pcaddu12i src1");
        check_word(ds_to_es_bus.src2, {i20, 12'b0}, "pcaddu12i imm");
        issue(enc_i12(6'h0a, 4'h6, si, 5'd7, 5'd8), 32'h2020);
        check_word(ds_to_es_bus.mem_we, 1, "st.w mem_we");
        check_word(ds_to_es_bus.rf_we, 0, "st.w rf_we");
        check_word(ds_to_es_bus.res_from_mem, 0, "st.w res_from_mem");
        check_word(ds_to_es_bus.store_data, reg_val[8], "st.w store_data");
        issue(enc_i12(6'h0a, 4'h2, si, 5'd7, 5'd8), 32'h2024);
        check_word(ds_to_es_bus.res_from_mem, 1, "ld.w res_from_mem");
        check_word(ds_to_es_bus.rf_we, 1, "ld.w rf_we");
        check_word(ds_to_es_bus.src2, {{20{si[11]}}, si}, "ld.w imm");
        end_test("immediates");
    endtask

    task automatic test_forwarding();
        logic [31:0] a, b, c;
        a = $urandom;
        b = $urandom;
        c = $urandom;
        err_start = errors;
        es_fwd   = '{1'b1, 1'b0, 5'd5, a};
        ms_fwd   = '{1'b1, 1'b0, 5'd5, b};
        ws_write = '{1'b1, 5'd5, c};
        issue(enc_3r(5'h00, 5'd6, 5'd5, 5'd2), 32'h3000);
        check_word(ds_to_es_bus.src1, a, "exe priority");
        check_word(ds_to_es_bus.src2, reg_val[6], "unforwarded rk");
        es_fwd = '0;
        issue(enc_3r(5'h00, 5'd6, 5'd5, 5'd2), 32'h3004);
        check_word(ds_to_es_bus.src1, b, "mem priority");
        ms_fwd = '0;
        issue(enc_3r(5'h00, 5'd6, 5'd5, 5'd2), 32'h3008);
        ws_write = '{1'b1, 5'd5, ~c}; // register file still holds c
        #1;
        check_word(ds_to_es_bus.src1, ~c, "writeback bypass");
        ws_write   = '0;
        reg_val[5] = c; // written at the edges above
        es_fwd = '{1'b1, 1'b0, 5'd0, a};
        issue(enc_3r(5'h00, 5'd0, 5'd0, 5'd2), 32'h300c);
        check_word(ds_to_es_bus.src1, 0, "r0 not forwarded");
        es_fwd = '0;
        end_test("forwarding");
    endtask

    task automatic test_load_use();
        logic [31:0] ld;
        ld = $urandom;
        err_start = errors;
        es_fwd = '{1'b1, 1'b1, 5'd8, 32'hdead_beef};
        issue(enc_3r(5'h00, 5'd9, 5'd8, 5'd2), 32'h4000);
        for (int i = 0; i < 3; i++) begin
            check_word(ds_to_es_valid, 0, "valid during stall");
            check_word(ds_allowin, 0, "allowin during stall");
            check_word(br_redirect.stall, 0, "redirect stall for alu op");
            @(posedge clk);
            #2;
        end
        es_fwd = '0;
        ms_fwd = '{1'b1, 1'b0, 5'd8, ld}; // load result now in mem
        #1;
        check_word(ds_to_es_valid, 1, "valid after release");
        check_word(ds_to_es_bus.src1, ld, "loaded value forwarded");
        @(posedge clk);
        #2;
        ms_fwd = '0;
        es_fwd = '{1'b1, 1'b1, 5'd8, 32'hdead_beef};
        issue({6'h05, 1'b0, 20'h12348, 5'd8}, 32'h4004); // rj field is r8
        check_word(ds_to_es_valid, 1, "no stall for lu12i.w");
        es_fwd = '{1'b1, 1'b1, 5'd10, 32'hdead_beef};
        issue(enc_br(6'h17, 26'h0008, 5'd10, 5'd11), 32'h4008);
        check_word(br_redirect.stall, 1, "branch waits on load");
        check_word(br_redirect.taken, 0, "taken during stall");
        es_fwd = '0;
        #1;
        check_word(br_redirect.stall, 0, "branch released");
        @(posedge clk);
        #2;
        end_test("load_use");
    endtask

    // issue a branch, offer a wrong-path instruction in its cycle, check both
    task automatic branch_step(input logic [31:0] inst, pc, input logic exp_taken,
                               input logic [31:0] exp_target);
        issue(inst, pc);
        last_bus = ds_to_es_bus;
        check_word(br_redirect.taken, exp_taken, "branch taken");
        if (exp_taken) check_word(br_redirect.target, exp_target, "branch target");
        fs_to_ds_valid = 1'b1;
        fs_to_ds_bus   = {enc_3r(5'h00, 5'd1, 5'd1, 5'd31), pc + 32'd4};
        @(posedge clk);
        #2;
        fs_to_ds_valid = 1'b0;
        check_word(ds_to_es_valid, !exp_taken, "wrong-path valid");
        if (!exp_taken) check_word(ds_to_es_bus.pc, pc + 32'd4, "fall-through pc");
        @(posedge clk);
        #2;
    endtask

    task automatic test_branches();
        logic [31:0] a, b, pc;
        logic [15:0] offs;
        logic [25:0] offs26;
        logic        exp;
        a = reg_val[10];
        b = reg_val[11];
        err_start = errors;
        for (int i = 0; i < 6; i++) begin
            offs = 16'($urandom);
            pc   = 32'h5000 + 32'(i * 16);
            case (i)
                0: exp = a == b;
                1: exp = a != b;
                2: exp = $signed(a) < $signed(b);
                3: exp = $signed(a) >= $signed(b);
                4: exp = a < b;
                default: exp = a >= b;
            endcase
            branch_step(enc_br(6'h16 + 6'(i), 26'(offs), 5'd10, 5'd11), pc, exp,
                        pc + sext_offs16(offs));
        end
        branch_step(enc_br(6'h16, 26'h0010, 5'd10, 5'd10), 32'h5100, 1, 32'h5140);
        offs26 = 26'($urandom);
        branch_step({6'h14, offs26[15:0], offs26[25:16]}, 32'h5200, 1,
                    32'h5200 + {{4{offs26[25]}}, offs26, 2'b00});
        branch_step({6'h15, offs26[15:0], offs26[25:16]}, 32'h5300, 1,
                    32'h5300 + {{4{offs26[25]}}, offs26, 2'b00});
        check_word(last_bus.dest, 1, "bl dest");
        check_word(last_bus.src1, 32'h5300, "bl src1");
        check_word(last_bus.src2, 4, "bl src2");
        branch_step(enc_br(6'h13, 26'h0021, 5'd13, 5'd14), 32'h5400, 1,
                    reg_val[13] + 32'h84);
        end_test("branches");
    endtask

    task automatic test_backpressure();
        pipe_pkg::decode_to_exe_t held;
        err_start = errors;
        es_allowin = 1'b0;
        issue(enc_3r(5'h0b, 5'd15, 5'd16, 5'd17), 32'h6000);
        held = ds_to_es_bus;
        fs_to_ds_valid = 1'b1;
        fs_to_ds_bus   = {enc_3r(5'h0a, 5'd18, 5'd19, 5'd20), 32'h6004};
        for (int i = 0; i < 3; i++) begin
            check_word(ds_allowin, 0, "allowin under back-pressure");
            check_word(ds_to_es_valid, 1, "valid under back-pressure");
            if (ds_to_es_bus !== held) begin
                errors++;
                $display("MISMATCH @%0t: bundle changed while execute was not ready", $time);
            end
            @(posedge clk);
            #2;
        end
        es_allowin = 1'b1;
        #1;
        check_word(ds_allowin, 1, "allowin on release");
        @(posedge clk);
        #2;
        fs_to_ds_valid = 1'b0;
        check_word(ds_to_es_valid, 1, "next valid");
        check_word(ds_to_es_bus.pc, 32'h6004, "next pc");
        @(posedge clk);
        #2;
        check_word(ds_to_es_valid, 0, "stage empty");
        end_test("backpressure");
    endtask

    initial begin
        void'($urandom(32'h4b76));
        clk            = 1'b0;
        resetn         = 1'b0;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus   = '0;
        es_allowin     = 1'b1;
        es_fwd         = '0;
        ms_fwd         = '0;
        ws_write       = '0;
        reg_val[0]     = '0;
        repeat (8) @(posedge clk);
        #2;
        resetn = 1'b1;
        check_word(ds_to_es_valid, 0, "valid after reset");
        check_word(ds_allowin, 1, "allowin after reset");
        check_word(br_redirect.taken, 0, "taken after reset");
        preload_regs();
        test_alu_reg();
        test_immediates();
        test_forwarding();
        test_load_use();
        test_branches();
        test_backpressure();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/id_stage_asserts.sv ====
`timescale 1ns/1ps

module id_stage_asserts (
    input logic                       clk,
    input logic                       resetn,
    input logic                       es_allowin,
    input logic                       ds_allowin,
    input logic                       ds_to_es_valid,
    input pipe_pkg::decode_to_exe_t   ds_to_es_bus,
    input pipe_pkg::branch_redirect_t br_redirect,
    input logic                       ds_valid,
    input logic                       load_use
);

    no_valid_after_reset: assert property (@(posedge clk) !resetn |=> !ds_to_es_valid)
        else $error("ds_to_es_valid high in the cycle after reset");

    bus_held: assert property (@(posedge clk) disable iff (!resetn)
        ds_to_es_valid && !es_allowin |=> $stable(ds_to_es_bus))
        else $error("ds_to_es_bus changed under back-pressure");

    taken_xor_stall: assert property (@(posedge clk) disable iff (!resetn)
        !(br_redirect.taken && br_redirect.stall))
        else $error("branch taken and stalled at once");

    // only a valid instruction can hold the stage
    allowin_low_on_stall: assert property (@(posedge clk) disable iff (!resetn)
        ds_valid && load_use |-> !ds_allowin)
        else $error("ds_allowin high during load-use stall");

endmodule

bind id_stage id_stage_asserts u_asserts (
    .clk            (clk),
    .resetn         (resetn),
    .es_allowin     (es_allowin),
    .ds_allowin     (ds_allowin),
    .ds_to_es_valid (ds_to_es_valid),
    .ds_to_es_bus   (ds_to_es_bus),
    .br_redirect    (br_redirect),
    .ds_valid       (ds_valid),
    .load_use       (load_use)
);

// ==== hw/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       fs_to_ds_valid,
    input  pipe_pkg::fetch_to_decode_t fs_to_ds_bus,
    input  logic                       es_allowin,
    input  pipe_pkg::fwd_src_t         es_fwd,
    input  pipe_pkg::fwd_src_t         ms_fwd,
    input  pipe_pkg::wb_write_t        ws_write,
    output logic                       ds_allowin,
    output logic                       ds_to_es_valid,
    output pipe_pkg::decode_to_exe_t   ds_to_es_bus,
    output pipe_pkg::branch_redirect_t br_redirect
);

    logic                       ds_valid;
    logic                       ds_ready_go;
    logic                       load_use;
    pipe_pkg::fetch_to_decode_t ds_buf;
    pipe_pkg::decode_ctrl_t     ctrl;
    isa_pkg::word_t             rj_value;
    isa_pkg::word_t             rkd_value;

    assign ds_ready_go    = ~load_use;
    assign ds_allowin     = ~ds_valid | ds_ready_go & es_allowin;
    assign ds_to_es_valid = ds_valid & ds_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid & ~br_redirect.taken; // drop wrong-path fetch
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_buf <= fs_to_ds_bus;
        end
    end

    inst_decoder u_inst_decoder (
        .inst (ds_buf.inst),
        .ctrl (ctrl)
    );

    operand_fetch u_operand_fetch (
        .clk           (clk),
        .rj            (ds_buf.inst[9:5]),
        .rk            (ds_buf.inst[14:10]),
        .rd            (ds_buf.inst[4:0]),
        .src_reg_is_rd (ctrl.src_reg_is_rd),
        .need_r1       (ctrl.need_r1),
        .need_r2       (ctrl.need_r2),
        .es_fwd        (es_fwd),
        .ms_fwd        (ms_fwd),
        .ws_write      (ws_write),
        .rj_value      (rj_value),
        .rkd_value     (rkd_value),
        .load_use      (load_use)
    );

    branch_unit u_branch_unit (
        .ctrl      (ctrl),
        .pc        (ds_buf.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .valid     (ds_valid),
        .stall     (ds_valid & load_use),
        .redirect  (br_redirect)
    );

    always_comb begin
        ds_to_es_bus.alu_op       = ctrl.alu_op;
        ds_to_es_bus.src1         = ctrl.src1_is_pc ? ds_buf.pc : rj_value;
        ds_to_es_bus.src2         = ctrl.src2_is_imm ? ctrl.imm : rkd_value;
        ds_to_es_bus.res_from_mem = ctrl.res_from_mem;
        ds_to_es_bus.mem_we       = ctrl.mem_we;
        ds_to_es_bus.rf_we        = ctrl.rf_we;
        ds_to_es_bus.dest         = ctrl.dest;
        ds_to_es_bus.store_data   = rkd_value; // st.w reads rd through the second port
        ds_to_es_bus.pc           = ds_buf.pc;
    end

endmodule

// ==== hw/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  pipe_pkg::decode_ctrl_t     ctrl,
    input  isa_pkg::word_t             pc,
    input  isa_pkg::word_t             rj_value,
    input  isa_pkg::word_t             rkd_value,
    input  logic                       valid,
    input  logic                       stall,
    output pipe_pkg::branch_redirect_t redirect
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond_met;
    logic is_jump;

    assign eq   = rj_value == rkd_value;
    assign lt_s = $signed(rj_value) < $signed(rkd_value);
    assign lt_u = rj_value < rkd_value;

    assign cond_met = ctrl.br_cond.beq  &  eq   | ctrl.br_cond.bne  & ~eq
                    | ctrl.br_cond.blt  &  lt_s | ctrl.br_cond.bge  & ~lt_s
                    | ctrl.br_cond.bltu &  lt_u | ctrl.br_cond.bgeu & ~lt_u;

    assign is_jump = ctrl.is_jirl | ctrl.is_b_uncond | (|ctrl.br_cond);

    always_comb begin
        redirect.stall  = stall & is_jump; // fetch must wait for the outcome
        redirect.taken  = valid & ~stall & (cond_met | ctrl.is_jirl | ctrl.is_b_uncond);
        redirect.target = (ctrl.is_jirl ? rj_value : pc) + ctrl.br_offs;
    end

endmodule

// ==== hw/operand_fetch.sv ====
`timescale 1ns/1ps

module operand_fetch (
    input  logic                clk,
    input  isa_pkg::reg_addr_t  rj,
    input  isa_pkg::reg_addr_t  rk,
    input  isa_pkg::reg_addr_t  rd,
    input  logic                src_reg_is_rd,
    input  logic                need_r1,
    input  logic                need_r2,
    input  pipe_pkg::fwd_src_t  es_fwd,
    input  pipe_pkg::fwd_src_t  ms_fwd,
    input  pipe_pkg::wb_write_t ws_write,
    output isa_pkg::word_t      rj_value,
    output isa_pkg::word_t      rkd_value,
    output logic                load_use
);

    isa_pkg::reg_addr_t raddr2;
    isa_pkg::word_t     rf_rdata1;
    isa_pkg::word_t     rf_rdata2;
    logic               es_hit1, es_hit2;
    logic               ms_hit1, ms_hit2;
    logic               ws_hit1, ws_hit2;

    function automatic logic fwd_hit(input pipe_pkg::fwd_src_t src,
                                     input isa_pkg::reg_addr_t addr);
        return src.rf_we && src.waddr == addr && addr != '0;
    endfunction

    assign raddr2 = src_reg_is_rd ? rd : rk; // stores and cond branches read rd

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rj),
        .raddr2 (raddr2),
        .write  (ws_write),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    assign es_hit1 = fwd_hit(es_fwd, rj);
    assign es_hit2 = fwd_hit(es_fwd, raddr2);
    assign ms_hit1 = fwd_hit(ms_fwd, rj);
    assign ms_hit2 = fwd_hit(ms_fwd, raddr2);
    assign ws_hit1 = ws_write.we && ws_write.waddr == rj && rj != '0;
    assign ws_hit2 = ws_write.we && ws_write.waddr == raddr2 && raddr2 != '0;

    // youngest producer wins
    assign rj_value  = es_hit1 ? es_fwd.wdata :
                       ms_hit1 ? ms_fwd.wdata :
                       ws_hit1 ? ws_write.wdata : rf_rdata1;
    assign rkd_value = es_hit2 ? es_fwd.wdata :
                       ms_hit2 ? ms_fwd.wdata :
                       ws_hit2 ? ws_write.wdata : rf_rdata2;

    // load data not there yet in exe or mem
    assign load_use = need_r1 & (es_hit1 & es_fwd.from_mem | ms_hit1 & ms_fwd.from_mem)
                    | need_r2 & (es_hit2 & es_fwd.from_mem | ms_hit2 & ms_fwd.from_mem);

endmodule

// ==== hw/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                clk,
    input  isa_pkg::reg_addr_t  raddr1,
    input  isa_pkg::reg_addr_t  raddr2,
    input  pipe_pkg::wb_write_t write,
    output isa_pkg::word_t      rdata1,
    output isa_pkg::word_t      rdata2
);

    isa_pkg::word_t regs [isa_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (write.we && write.waddr != '0) begin
            regs[write.waddr] <= write.wdata;
        end
    end

    // r0 hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== hw/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  isa_pkg::inst_t         inst,
    output pipe_pkg::decode_ctrl_t ctrl
);

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;
    logic        is_3r;
    logic        is_shift;
    logic        is_opi;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic        inst_nor, inst_and, inst_or, inst_xor;
    logic        inst_slli_w, inst_srli_w, inst_srai_w;
    logic        inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic        inst_lu12i_w, inst_pcaddu12i, inst_ld_w, inst_st_w;
    logic        inst_jirl, inst_b, inst_bl;
    logic        need_ui5, need_si12, need_ui12, need_si20, src2_is_4;
    logic        any_cond;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    assign i12 = inst[21:10];
    assign i16 = inst[25:10];
    assign i20 = inst[24:5];
    assign i26 = {inst[9:0], inst[25:10]}; // offs[25:16] sits in the low bits

    assign is_opi   = op_31_26 == isa_pkg::OP6_ALU;
    assign is_3r    = is_opi & (op_25_22 == isa_pkg::OP4_3R) & (op_21_20 == isa_pkg::OP2_3R);
    assign is_shift = is_opi & (op_25_22 == isa_pkg::OP4_SHIFT)
                    & (op_21_20 == isa_pkg::OP2_SHIFT);

    assign inst_add_w  = is_3r & (op_19_15 == isa_pkg::OP5_ADD);
    assign inst_sub_w  = is_3r & (op_19_15 == isa_pkg::OP5_SUB);
    assign inst_slt    = is_3r & (op_19_15 == isa_pkg::OP5_SLT);
    assign inst_sltu   = is_3r & (op_19_15 == isa_pkg::OP5_SLTU);
    assign inst_nor    = is_3r & (op_19_15 == isa_pkg::OP5_NOR);
    assign inst_and    = is_3r & (op_19_15 == isa_pkg::OP5_AND);
    assign inst_or     = is_3r & (op_19_15 == isa_pkg::OP5_OR);
    assign inst_xor    = is_3r & (op_19_15 == isa_pkg::OP5_XOR);
    assign inst_slli_w = is_shift & (op_19_15 == isa_pkg::OP5_SLLI);
    assign inst_srli_w = is_shift & (op_19_15 == isa_pkg::OP5_SRLI);
    assign inst_srai_w = is_shift & (op_19_15 == isa_pkg::OP5_SRAI);

    assign inst_addi_w = is_opi & (op_25_22 == isa_pkg::OP4_ADDI);
    assign inst_slti   = is_opi & (op_25_22 == isa_pkg::OP4_SLTI);
    assign inst_sltui  = is_opi & (op_25_22 == isa_pkg::OP4_SLTUI);
    assign inst_andi   = is_opi & (op_25_22 == isa_pkg::OP4_ANDI);
    assign inst_ori    = is_opi & (op_25_22 == isa_pkg::OP4_ORI);
    assign inst_xori   = is_opi & (op_25_22 == isa_pkg::OP4_XORI);

    assign inst_lu12i_w   = (op_31_26 == isa_pkg::OP6_LU12I) & ~inst[25];
    assign inst_pcaddu12i = (op_31_26 == isa_pkg::OP6_PCADDU12I) & ~inst[25];
    assign inst_ld_w      = (op_31_26 == isa_pkg::OP6_MEM) & (op_25_22 == isa_pkg::OP4_LD_W);
    assign inst_st_w      = (op_31_26 == isa_pkg::OP6_MEM) & (op_25_22 == isa_pkg::OP4_ST_W);
    assign inst_jirl      = op_31_26 == isa_pkg::OP6_JIRL;
    assign inst_b         = op_31_26 == isa_pkg::OP6_B;
    assign inst_bl        = op_31_26 == isa_pkg::OP6_BL;

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si12 = inst_addi_w | inst_slti | inst_sltui | inst_ld_w | inst_st_w;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
    assign src2_is_4 = inst_jirl | inst_bl; // link value pc+4

    always_comb begin
        ctrl.br_cond.beq  = op_31_26 == isa_pkg::OP6_BEQ;
        ctrl.br_cond.bne  = op_31_26 == isa_pkg::OP6_BNE;
        ctrl.br_cond.blt  = op_31_26 == isa_pkg::OP6_BLT;
        ctrl.br_cond.bge  = op_31_26 == isa_pkg::OP6_BGE;
        ctrl.br_cond.bltu = op_31_26 == isa_pkg::OP6_BLTU;
        ctrl.br_cond.bgeu = op_31_26 == isa_pkg::OP6_BGEU;
        any_cond          = |ctrl.br_cond;

        ctrl.alu_op = {inst_lu12i_w, inst_srai_w, inst_srli_w, inst_slli_w,
                       inst_xor | inst_xori, inst_or | inst_ori, inst_nor,
                       inst_and | inst_andi, inst_sltu | inst_sltui, inst_slt | inst_slti,
                       inst_sub_w,
                       inst_add_w | inst_addi_w | inst_ld_w | inst_st_w | inst_jirl
                       | inst_bl | inst_pcaddu12i};

        ctrl.imm = {32{src2_is_4}} & 32'd4
                 | {32{need_si20}} & {i20, 12'b0}
                 | {32{need_si12}} & {{20{i12[11]}}, i12}
                 | {32{need_ui12}} & {20'b0, i12}
                 | {32{need_ui5}}  & {27'b0, inst[14:10]};

        ctrl.br_offs = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b0}
                                          : {{14{i16[15]}}, i16, 2'b0};

        ctrl.src1_is_pc    = inst_jirl | inst_bl | inst_pcaddu12i;
        ctrl.src2_is_imm   = need_ui5 | need_si12 | need_ui12 | need_si20 | src2_is_4;
        ctrl.src_reg_is_rd = inst_st_w | any_cond;
        // jirl reads rj for its target even though src1 is the pc
        ctrl.need_r1 = is_3r | need_ui5 | need_si12 | need_ui12 | inst_jirl | any_cond;
        ctrl.need_r2 = is_3r | inst_st_w | any_cond;
        ctrl.rf_we   = is_3r | need_ui5 | need_ui12 | need_si20 | inst_addi_w | inst_slti
                     | inst_sltui | inst_ld_w | inst_jirl | inst_bl;
        ctrl.dest         = inst_bl ? isa_pkg::REG_R1 : inst[4:0];
        ctrl.res_from_mem = inst_ld_w;
        ctrl.mem_we       = inst_st_w;
        ctrl.is_jirl      = inst_jirl;
        ctrl.is_b_uncond  = inst_b | inst_bl;
    end

endmodule

// ==== hw/pipe_pkg.sv ====
package pipe_pkg;

    typedef struct packed {
        isa_pkg::inst_t inst;
        isa_pkg::word_t pc;
    } fetch_to_decode_t;

    // write-back intent of exe or mem, seen by decode
    typedef struct packed {
        logic               rf_we;
        logic               from_mem;
        isa_pkg::reg_addr_t waddr;
        isa_pkg::word_t     wdata;
    } fwd_src_t;

    typedef struct packed {
        logic               we;
        isa_pkg::reg_addr_t waddr;
        isa_pkg::word_t     wdata;
    } wb_write_t;

    typedef struct packed {
        logic beq;
        logic bne;
        logic blt;
        logic bge;
        logic bltu;
        logic bgeu;
    } br_cond_t;

    typedef struct packed {
        isa_pkg::alu_op_t   alu_op;
        logic               src1_is_pc;
        logic               src2_is_imm;
        isa_pkg::word_t     imm;
        logic               need_r1;
        logic               need_r2;
        logic               src_reg_is_rd;
        logic               rf_we;
        isa_pkg::reg_addr_t dest;
        logic               res_from_mem;
        logic               mem_we;
        logic               is_jirl;
        logic               is_b_uncond; // b and bl
        br_cond_t           br_cond;
        isa_pkg::word_t     br_offs;
    } decode_ctrl_t;

    typedef struct packed {
        logic           stall;
        logic           taken;
        isa_pkg::word_t target;
    } branch_redirect_t;

    typedef struct packed {
        isa_pkg::alu_op_t   alu_op;
        isa_pkg::word_t     src1;
        isa_pkg::word_t     src2;
        logic               res_from_mem;
        logic               mem_we;
        logic               rf_we;
        isa_pkg::reg_addr_t dest;
        isa_pkg::word_t     store_data;
        isa_pkg::word_t     pc;
    } decode_to_exe_t;

endpackage

// ==== hw/isa_pkg.sv ====
package isa_pkg;

    localparam int NUM_REGS = 32;
    localparam int ALU_OP_W = 12;

    typedef logic [31:0]         word_t;
    typedef logic [31:0]         inst_t;
    typedef logic [4:0]          reg_addr_t;
    // bit 0 first: add sub slt sltu and nor or xor sll srl sra lui
    typedef logic [ALU_OP_W-1:0] alu_op_t;

    localparam reg_addr_t REG_R1 = 5'd1; // link register for bl

    // op_31_26
    localparam logic [5:0] OP6_ALU       = 6'h00;
    localparam logic [5:0] OP6_LU12I     = 6'h05;
    localparam logic [5:0] OP6_PCADDU12I = 6'h07;
    localparam logic [5:0] OP6_MEM       = 6'h0a;
    localparam logic [5:0] OP6_JIRL      = 6'h13;
    localparam logic [5:0] OP6_B         = 6'h14;
    localparam logic [5:0] OP6_BL        = 6'h15;
    localparam logic [5:0] OP6_BEQ       = 6'h16;
    localparam logic [5:0] OP6_BNE       = 6'h17;
    localparam logic [5:0] OP6_BLT       = 6'h18;
    localparam logic [5:0] OP6_BGE       = 6'h19;
    localparam logic [5:0] OP6_BLTU      = 6'h1a;
    localparam logic [5:0] OP6_BGEU      = 6'h1b;

    // op_25_22
    localparam logic [3:0] OP4_3R    = 4'h0;
    localparam logic [3:0] OP4_SHIFT = 4'h1;
    localparam logic [3:0] OP4_LD_W  = 4'h2;
    localparam logic [3:0] OP4_ST_W  = 4'h6;
    localparam logic [3:0] OP4_SLTI  = 4'h8;
    localparam logic [3:0] OP4_SLTUI = 4'h9;
    localparam logic [3:0] OP4_ADDI  = 4'ha;
    localparam logic [3:0] OP4_ANDI  = 4'hd;
    localparam logic [3:0] OP4_ORI   = 4'he;
    localparam logic [3:0] OP4_XORI  = 4'hf;

    // op_21_20
    localparam logic [1:0] OP2_3R    = 2'h1;
    localparam logic [1:0] OP2_SHIFT = 2'h0;

    // op_19_15
    localparam logic [4:0] OP5_ADD  = 5'h00;
    localparam logic [4:0] OP5_SUB  = 5'h02;
    localparam logic [4:0] OP5_SLT  = 5'h04;
    localparam logic [4:0] OP5_SLTU = 5'h05;
    localparam logic [4:0] OP5_NOR  = 5'h08;
    localparam logic [4:0] OP5_AND  = 5'h09;
    localparam logic [4:0] OP5_OR   = 5'h0a;
    localparam logic [4:0] OP5_XOR  = 5'h0b;
    localparam logic [4:0] OP5_SLLI = 5'h01;
    localparam logic [4:0] OP5_SRLI = 5'h09;
    localparam logic [4:0] OP5_SRAI = 5'h11;

endpackage
